/* verilog/mcu_protocol_pkg.sv */
package mcu_protocol_pkg;

    // ==============================
    // SPI byte protocol
    // ==============================

    typedef logic [7:0] byte_t;

    // First byte of every frame
    typedef enum logic [7:0] {
        CMD_IDENTIFY  = 8'd0,
        CMD_REG_READ  = 8'd1,
        CMD_REG_WRITE = 8'd2,
        CMD_MEM_READ  = 8'd3,
        CMD_MEM_WRITE = 8'd4
    } mcu_cmd_e;

    // Position inside a frame
    typedef enum logic [1:0] {
        PHASE_CMD,
        PHASE_ADDRESS,
        PHASE_DATA
    } phase_e;

    localparam byte_t FPGA_ID = 8'h64;  // Returned to an identify command

endpackage

/* verilog/mcu_regs_pkg.sv */
package mcu_regs_pkg;

    // ==============================
    // Register map
    // ==============================

    typedef logic [31:0] reg_word_t;

    typedef enum logic [7:0] {
        REG_STATUS      = 8'd0,
        REG_MEM_ADDRESS = 8'd1,
        REG_MEM_SCR     = 8'd2
    } reg_addr_e;

    // STATUS fields
    localparam int STATUS_BUTTON_BIT = 0;
    localparam int STATUS_SD_DET_BIT = 1;
    localparam int STATUS_BUSY_BIT   = 2;

    // MEM_SCR fields
    localparam int SCR_START_BIT     = 0;
    localparam int SCR_STOP_BIT      = 1;
    localparam int SCR_DIRECTION_BIT = 2;  // Set means buffer to bus
    localparam int SCR_BUSY_BIT      = 3;
    localparam int SCR_LENGTH_LSB    = 5;
    localparam int SCR_LENGTH_MSB    = 14;

    // ==============================
    // Transfer buffer and memory bus
    // ==============================

    typedef logic [15:0] mem_word_t;
    typedef logic [31:0] mem_addr_t;
    typedef logic [8:0] buf_index_t;

    localparam int BUF_DEPTH = 512;
    localparam int SYNC_STAGES = 3;

endpackage

/* verilog/mcu_spi_link.sv */
`timescale 1ns/10ps

module mcu_spi_link
    import mcu_protocol_pkg::*;
    import mcu_regs_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  mcu_clk,
    input  logic  mcu_cs,
    input  logic  mcu_mosi,
    input  byte_t tx_data,
    output logic  mcu_miso,
    output logic  frame_start,
    output logic  data_ready,
    output byte_t rx_data
);

    logic [SYNC_STAGES-1:0] clk_ff;
    logic [SYNC_STAGES-1:0] cs_ff;
    logic [SYNC_STAGES-1:0] mosi_ff;
    logic clk_last;
    logic cs_last;
    logic cs_active;
    logic spi_rise;
    logic spi_fall;
    logic [2:0] bit_count;
    logic ready_d1;
    logic ready_d2;
    logic start_d1;
    byte_t tx_shift;

    // Pin synchronizers, idle state is chip select high and clock low
    always_ff @(posedge clk) begin
        if (reset) begin
            clk_ff <= '0;
            cs_ff <= '1;
            mosi_ff <= '0;
            clk_last <= 1'b0;
            cs_last <= 1'b1;
        end else begin
            clk_ff <= {clk_ff[SYNC_STAGES-2:0], mcu_clk};
            cs_ff <= {cs_ff[SYNC_STAGES-2:0], mcu_cs};
            mosi_ff <= {mosi_ff[SYNC_STAGES-2:0], mcu_mosi};
            clk_last <= clk_ff[SYNC_STAGES-1];
            cs_last <= cs_ff[SYNC_STAGES-1];
        end
    end

    assign cs_active = ~cs_ff[SYNC_STAGES-1];
    assign spi_rise = cs_active & clk_ff[SYNC_STAGES-1] & ~clk_last;
    assign spi_fall = cs_active & ~clk_ff[SYNC_STAGES-1] & clk_last;
    assign frame_start = cs_last & ~cs_ff[SYNC_STAGES-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            bit_count <= 3'd0;
            data_ready <= 1'b0;
            ready_d1 <= 1'b0;
            ready_d2 <= 1'b0;
            start_d1 <= 1'b0;
            tx_shift <= '0;
        end else begin
            data_ready <= 1'b0;
            ready_d1 <= data_ready;
            ready_d2 <= ready_d1;  // Decoder needs two cycles to select the response
            start_d1 <= frame_start;

            if (!cs_active) begin
                bit_count <= 3'd0;
            end else if (spi_rise) begin
                rx_data <= {rx_data[6:0], mosi_ff[SYNC_STAGES-1]};
                bit_count <= bit_count + 3'd1;
                data_ready <= (bit_count == 3'd7);
            end

            // The falling edge after the last bit must not shift out the next byte
            if (ready_d2 || start_d1) begin
                tx_shift <= tx_data;
            end else if (spi_fall && (bit_count != 3'd0)) begin
                tx_shift <= {tx_shift[6:0], 1'b0};
            end
        end
    end

    assign mcu_miso = tx_shift[7];

endmodule

/* verilog/mcu_command_decoder.sv */
`timescale 1ns/10ps

module mcu_command_decoder
    import mcu_protocol_pkg::*;
    import mcu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       frame_start,
    input  logic       data_ready,
    input  byte_t      rx_data,
    input  reg_word_t  reg_rdata,
    input  mem_word_t  buf_rdata,
    output byte_t      tx_data,
    output logic       reg_read,
    output logic       reg_write,
    output reg_addr_e  reg_address,
    output reg_word_t  reg_wdata,
    output logic       mem_read,
    output logic       mem_write,
    output buf_index_t buf_index,
    output mem_word_t  buf_wdata
);

    phase_e phase;
    mcu_cmd_e cmd;
    logic [1:0] counter;
    logic [7:0] address;
    logic word_select;

    // ==============================
    // Frame state machine
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PHASE_CMD;
            cmd <= CMD_IDENTIFY;
            counter <= 2'd0;
            address <= 8'd0;
            word_select <= 1'b0;
            reg_read <= 1'b0;
            reg_write <= 1'b0;
            mem_read <= 1'b0;
            mem_write <= 1'b0;
        end else begin
            reg_read <= 1'b0;
            reg_write <= 1'b0;
            mem_read <= 1'b0;
            mem_write <= 1'b0;

            if (frame_start) begin
                counter <= 2'd0;
                phase <= PHASE_CMD;
            end

            // Step to the next item once the current one has been accessed
            if (reg_read || reg_write || (word_select && (mem_read || mem_write))) begin
                address <= address + 8'd1;
            end

            if (data_ready) begin
                case (phase)
                    PHASE_CMD: begin
                        cmd <= mcu_cmd_e'(rx_data);
                        phase <= PHASE_ADDRESS;
                    end

                    PHASE_ADDRESS: begin
                        address <= rx_data;
                        phase <= PHASE_DATA;
                        if (cmd == CMD_REG_READ) begin
                            reg_read <= 1'b1;  // Prefetch the first register
                        end
                        if (cmd == CMD_MEM_READ) begin
                            mem_read <= 1'b1;
                            word_select <= 1'b0;
                        end
                    end

                    PHASE_DATA: begin
                        counter <= counter + 2'd1;
                        if ((cmd == CMD_REG_READ) && (counter == 2'd3)) begin
                            reg_read <= 1'b1;
                        end
                        if ((cmd == CMD_REG_WRITE) && (counter == 2'd3)) begin
                            reg_write <= 1'b1;
                        end
                        if ((cmd == CMD_MEM_READ) && counter[0]) begin
                            mem_read <= 1'b1;
                            word_select <= ~word_select;
                        end
                        if ((cmd == CMD_MEM_WRITE) && counter[0]) begin
                            mem_write <= 1'b1;
                            word_select <= counter[1];
                        end
                    end

                    default: begin
                        phase <= PHASE_CMD;
                    end
                endcase
            end
        end
    end

    // ==============================
    // Word assembly
    // ==============================

    always_ff @(posedge clk) begin
        if (data_ready && (phase == PHASE_DATA)) begin
            if (cmd == CMD_REG_WRITE) begin
                reg_wdata[{counter, 3'b000} +: 8] <= rx_data;  // Least significant byte first
            end
            if (cmd == CMD_MEM_WRITE) begin
                if (counter[0]) begin
                    buf_wdata[7:0] <= rx_data;
                end else begin
                    buf_wdata[15:8] <= rx_data;
                end
            end
        end
    end

    assign reg_address = reg_addr_e'(address);
    assign buf_index = {address, word_select};

    // Response byte for the data byte in progress
    always_comb begin
        tx_data = 8'h00;
        case (cmd)
            CMD_IDENTIFY: tx_data = FPGA_ID;
            CMD_REG_READ: tx_data = reg_rdata[{counter, 3'b000} +: 8];
            CMD_MEM_READ: tx_data = counter[0] ? buf_rdata[7:0] : buf_rdata[15:8];
            default:      tx_data = 8'h00;
        endcase
    end

endmodule

/* verilog/mcu_register_block.sv */
`timescale 1ns/10ps

module mcu_register_block
    import mcu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       button,
    input  logic       sd_det,
    input  logic       reg_read,
    input  logic       reg_write,
    input  reg_addr_e  reg_address,
    input  reg_word_t  reg_wdata,
    input  logic       xfer_busy,
    output reg_word_t  reg_rdata,
    output logic       xfer_start,
    output logic       xfer_stop,
    output logic       xfer_direction,
    output buf_index_t xfer_length,
    output mem_addr_t  xfer_address
);

    logic [SYNC_STAGES-1:0] button_ff;
    logic [SYNC_STAGES-1:0] sd_det_ff;
    reg_word_t read_value;

    always_ff @(posedge clk) begin
        button_ff <= {button_ff[SYNC_STAGES-2:0], button};
        sd_det_ff <= {sd_det_ff[SYNC_STAGES-2:0], sd_det};
    end

    always_comb begin
        read_value = '0;  // Unmapped addresses read as zero
        case (reg_address)
            REG_STATUS: begin
                read_value[STATUS_BUTTON_BIT] = button_ff[SYNC_STAGES-1];
                read_value[STATUS_SD_DET_BIT] = sd_det_ff[SYNC_STAGES-1];
                read_value[STATUS_BUSY_BIT] = xfer_busy;
            end
            REG_MEM_ADDRESS: read_value = xfer_address;
            REG_MEM_SCR: read_value[SCR_BUSY_BIT] = xfer_busy;
            default: read_value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            reg_rdata <= '0;
            xfer_start <= 1'b0;
            xfer_stop <= 1'b0;
            xfer_direction <= 1'b0;
            xfer_length <= '0;
            xfer_address <= '0;
        end else begin
            xfer_start <= 1'b0;
            xfer_stop <= 1'b0;
            if (reg_read) begin
                reg_rdata <= read_value;
            end
            if (reg_write && (reg_address == REG_MEM_ADDRESS)) begin
                xfer_address <= reg_wdata;
            end
            if (reg_write && (reg_address == REG_MEM_SCR)) begin
                xfer_start <= reg_wdata[SCR_START_BIT];
                xfer_stop <= reg_wdata[SCR_STOP_BIT];
                xfer_direction <= reg_wdata[SCR_DIRECTION_BIT];
                // Kept as last word index for the engine's compare
                xfer_length <= buf_index_t'(reg_wdata[SCR_LENGTH_MSB:SCR_LENGTH_LSB] - 10'd1);
            end
        end
    end

endmodule

/* verilog/mem_transfer_engine.sv */
`timescale 1ns/10ps

module mem_transfer_engine
    import mcu_regs_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       mem_read,
    input  logic       mem_write,
    input  buf_index_t buf_index,
    input  mem_word_t  buf_wdata,
    input  logic       xfer_start,
    input  logic       xfer_stop,
    input  logic       xfer_direction,
    input  buf_index_t xfer_length,
    input  mem_addr_t  xfer_address,
    input  logic       mem_ack,
    input  mem_word_t  mem_rdata,
    output mem_word_t  buf_rdata,
    output logic       xfer_busy,
    output logic       mem_request,
    output logic       mem_write_dir,
    output mem_addr_t  mem_address,
    output mem_word_t  mem_wdata
);

    mem_word_t buffer [BUF_DEPTH];
    buf_index_t word_count;
    logic stop_pending;

    // ==============================
    // Transfer buffer
    // ==============================

    always_ff @(posedge clk) begin
        if (mem_read) begin
            buf_rdata <= buffer[buf_index];
        end
        if (mem_write) begin
            buffer[buf_index] <= buf_wdata;
        end
        if (xfer_busy && !mem_request) begin
            mem_wdata <= buffer[word_count];  // Held for the whole request
        end
        if (xfer_busy && mem_ack && !mem_write_dir) begin
            buffer[word_count] <= mem_rdata;
        end
    end

    // ==============================
    // Burst master
    // ==============================

    always_ff @(posedge clk) begin
        if (reset) begin
            xfer_busy <= 1'b0;
            stop_pending <= 1'b0;
            mem_request <= 1'b0;
            mem_write_dir <= 1'b0;
            mem_address <= '0;
            word_count <= '0;
        end else begin
            if (xfer_stop) begin
                stop_pending <= xfer_busy;
            end else if (xfer_start && !xfer_busy) begin
                mem_write_dir <= xfer_direction;
                mem_address <= xfer_address;
                word_count <= '0;
                xfer_busy <= 1'b1;
            end

            if (xfer_busy) begin
                if (!mem_request) begin
                    mem_request <= 1'b1;
                end
                if (mem_ack) begin
                    mem_request <= 1'b0;  // Gap of at least one cycle between words
                    mem_address <= mem_address + 32'd2;
                    word_count <= word_count + 9'd1;
                    if ((word_count == xfer_length) || stop_pending) begin
                        xfer_busy <= 1'b0;
                        stop_pending <= 1'b0;
                    end
                end
            end
        end
    end

endmodule

/* verilog/mcu_bridge_top.sv */
`timescale 1ns/10ps

module mcu_bridge_top
    import mcu_protocol_pkg::*;
    import mcu_regs_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      button,
    input  logic      sd_det,
    input  logic      mcu_clk,
    input  logic      mcu_cs,
    input  logic      mcu_mosi,
    output logic      mcu_miso,
    output logic      mem_request,
    input  logic      mem_ack,
    output logic      mem_write,
    output mem_addr_t mem_address,
    output mem_word_t mem_wdata,
    input  mem_word_t mem_rdata
);

    logic frame_start;
    logic data_ready;
    byte_t rx_data;
    byte_t tx_data;

    logic reg_read;
    logic reg_write;
    reg_addr_e reg_address;
    reg_word_t reg_wdata;
    reg_word_t reg_rdata;

    logic buf_read;
    logic buf_write;
    buf_index_t buf_index;
    mem_word_t buf_wdata;
    mem_word_t buf_rdata;

    logic xfer_start;
    logic xfer_stop;
    logic xfer_direction;
    buf_index_t xfer_length;
    mem_addr_t xfer_address;
    logic xfer_busy;

    mcu_spi_link spi_link_inst (
        .clk(clk),
        .reset(reset),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .tx_data(tx_data),
        .mcu_miso(mcu_miso),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data)
    );

    mcu_command_decoder decoder_inst (
        .clk(clk),
        .reset(reset),
        .frame_start(frame_start),
        .data_ready(data_ready),
        .rx_data(rx_data),
        .reg_rdata(reg_rdata),
        .buf_rdata(buf_rdata),
        .tx_data(tx_data),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .mem_read(buf_read),
        .mem_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata)
    );

    mcu_register_block register_block_inst (
        .clk(clk),
        .reset(reset),
        .button(button),
        .sd_det(sd_det),
        .reg_read(reg_read),
        .reg_write(reg_write),
        .reg_address(reg_address),
        .reg_wdata(reg_wdata),
        .xfer_busy(xfer_busy),
        .reg_rdata(reg_rdata),
        .xfer_start(xfer_start),
        .xfer_stop(xfer_stop),
        .xfer_direction(xfer_direction),
        .xfer_length(xfer_length),
        .xfer_address(xfer_address)
    );

    mem_transfer_engine transfer_engine_inst (
        .clk(clk),
        .reset(reset),
        .mem_read(buf_read),
        .mem_write(buf_write),
        .buf_index(buf_index),
        .buf_wdata(buf_wdata),
        .xfer_start(xfer_start),
        .xfer_stop(xfer_stop),
        .xfer_direction(xfer_direction),
        .xfer_length(xfer_length),
        .xfer_address(xfer_address),
        .mem_ack(mem_ack),
        .mem_rdata(mem_rdata),
        .buf_rdata(buf_rdata),
        .xfer_busy(xfer_busy),
        .mem_request(mem_request),
        .mem_write_dir(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata)
    );

endmodule

/* testbench/mcu_bridge_assertions.sv */
`timescale 1ns/10ps

module mcu_bridge_assertions
    import mcu_regs_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      mem_request,
    input logic      mem_ack,
    input logic      mem_write,
    input mem_addr_t mem_address,
    input mem_word_t mem_wdata
);

    int failure_count = 0;  // Read by the testbench at the end of the run

    // ==============================
    // Memory bus request rules
    // ==============================

    request_held: assert property (@(posedge clk) disable iff (reset)
        (mem_request && !mem_ack) |=> mem_request)
        else begin
            failure_count++;
            $error("mem_request dropped before mem_ack");
        end

    ack_in_request: assert property (@(posedge clk) disable iff (reset)
        mem_ack |-> mem_request)
        else begin
            failure_count++;
            $error("mem_ack outside of a request");
        end

    address_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_request && !mem_ack) |=> $stable(mem_address))
        else begin
            failure_count++;
            $error("mem_address changed during a request");
        end

    // Write data only carries meaning on buffer to bus requests
    wdata_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_request && mem_write && !mem_ack) |=> $stable(mem_wdata))
        else begin
            failure_count++;
            $error("mem_wdata changed during a request");
        end

endmodule

bind mcu_bridge_top mcu_bridge_assertions bus_checks (
    .clk(clk),
    .reset(reset),
    .mem_request(mem_request),
    .mem_ack(mem_ack),
    .mem_write(mem_write),
    .mem_address(mem_address),
    .mem_wdata(mem_wdata)
);

/* testbench/tb_mcu_bridge.sv */
`timescale 1ns/10ps

module tb_mcu_bridge
    import mcu_protocol_pkg::*;
    import mcu_regs_pkg::*;
();

    logic clk;
    logic reset;
    logic button;
    logic sd_det;
    logic mcu_clk;
    logic mcu_cs;
    logic mcu_mosi;
    logic mcu_miso;
    logic mem_request;
    logic mem_ack;
    logic mem_write;
    mem_addr_t mem_address;
    mem_word_t mem_wdata;
    mem_word_t mem_rdata;

    logic [31:0] lcg_state;
    int ack_wait;
    int ack_count;
    mem_addr_t bus_log_addr [BUF_DEPTH];
    mem_word_t bus_log_data [BUF_DEPTH];
    logic bus_log_write [BUF_DEPTH];
    mem_word_t buf_words [BUF_DEPTH];
    mem_word_t read_words [BUF_DEPTH];
    reg_word_t reg_values [4];

    mcu_bridge_top UUT (
        .clk(clk),
        .reset(reset),
        .button(button),
        .sd_det(sd_det),
        .mcu_clk(mcu_clk),
        .mcu_cs(mcu_cs),
        .mcu_mosi(mcu_mosi),
        .mcu_miso(mcu_miso),
        .mem_request(mem_request),
        .mem_ack(mem_ack),
        .mem_write(mem_write),
        .mem_address(mem_address),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ==============================
    // Reference and helpers
    // ==============================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Bus memory contents, a pattern over the whole address
    function automatic mem_word_t mem_ref_word(input mem_addr_t address);
        return address[31:16] ^ {address[7:0], address[15:8]} ^ 16'h5a3c;
    endfunction

    function automatic reg_word_t status_ref(input logic btn, input logic det, input logic busy);
        reg_word_t value;
        value = '0;
        value[STATUS_BUTTON_BIT] = btn;
        value[STATUS_SD_DET_BIT] = det;
        value[STATUS_BUSY_BIT] = busy;
        return value;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_byte(input string name, input byte_t actual, input byte_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_reg(input string name, input reg_word_t actual, input reg_word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_mem_word(input string name, input mem_word_t actual,
                                  input mem_word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic check_address(input string name, input mem_addr_t actual,
                                 input mem_addr_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERR %s: got %h, expected %h", name, actual, expected));
        end
    endtask

    task automatic clk_cycles(input int count);
        repeat (count) @(negedge clk);
    endtask

    // ==============================
    // Memory bus model
    // ==============================

    always @(negedge clk) begin
        if (reset) begin
            mem_ack = 1'b0;
            ack_wait = 0;
        end else if (mem_ack) begin
            mem_ack = 1'b0;  // Request drops on the same rising edge
        end else if (mem_request) begin
            if (ack_wait == 0) begin
                ack_wait = 1 + int'((lcg_next() >> 16) % 32'd4);
            end
            ack_wait = ack_wait - 1;
            if (ack_wait == 0) begin
                if (!mem_write) begin
                    mem_rdata = mem_ref_word(mem_address);
                end
                if (ack_count < BUF_DEPTH) begin
                    bus_log_addr[ack_count] = mem_address;
                    bus_log_data[ack_count] = mem_wdata;
                    bus_log_write[ack_count] = mem_write;
                end
                ack_count = ack_count + 1;
                mem_ack = 1'b1;
            end
        end
    end

    // Bus protocol assertions end the run on their first failure
    always @(negedge clk) begin
        if (UUT.bus_checks.failure_count != 0) begin
            abort_run("A memory bus protocol assertion failed");
        end
    end

    // ==============================
    // SPI master
    // ==============================

    // Mode 0, MISO is sampled at the end of each low phase
    task automatic spi_byte(input byte_t tx, output byte_t rx);
        for (int i = 7; i >= 0; i--) begin
            mcu_mosi = tx[i];
            clk_cycles(6);
            rx[i] = mcu_miso;
            mcu_clk = 1'b1;
            clk_cycles(6);
            mcu_clk = 1'b0;
        end
        clk_cycles(10);  // Room for the next response byte to load
    endtask

    task automatic frame_begin(input byte_t command);
        byte_t ignored;
        mcu_cs = 1'b0;
        clk_cycles(8);
        spi_byte(command, ignored);
    endtask

    task automatic frame_end();
        mcu_cs = 1'b1;
        clk_cycles(8);
    endtask

    task automatic write_register(input reg_addr_e address, input reg_word_t value);
        byte_t ignored;
        frame_begin(CMD_REG_WRITE);
        spi_byte(address, ignored);
        for (int i = 0; i < 4; i++) begin
            spi_byte(value[8*i +: 8], ignored);  // Least significant byte first
        end
        frame_end();
    endtask

    task automatic read_registers(input reg_addr_e first, input int count);
        byte_t rx;
        frame_begin(CMD_REG_READ);
        spi_byte(first, rx);
        for (int r = 0; r < count; r++) begin
            for (int i = 0; i < 4; i++) begin
                spi_byte(8'h00, rx);
                reg_values[r][8*i +: 8] = rx;
            end
        end
        frame_end();
    endtask

    task automatic write_buffer(input int count);
        byte_t ignored;
        frame_begin(CMD_MEM_WRITE);
        spi_byte(8'h00, ignored);
        for (int k = 0; k < count; k++) begin
            spi_byte(buf_words[k][15:8], ignored);
            spi_byte(buf_words[k][7:0], ignored);
        end
        frame_end();
    endtask

    task automatic read_buffer(input int count);
        byte_t rx;
        frame_begin(CMD_MEM_READ);
        spi_byte(8'h00, rx);
        for (int k = 0; k < count; k++) begin
            spi_byte(8'h00, rx);
            read_words[k][15:8] = rx;
            spi_byte(8'h00, rx);
            read_words[k][7:0] = rx;
        end
        frame_end();
    endtask

    task automatic start_transfer(input logic to_bus, input mem_addr_t address, input int length);
        reg_word_t scr;
        scr = '0;
        scr[SCR_START_BIT] = 1'b1;
        scr[SCR_DIRECTION_BIT] = to_bus;
        scr[SCR_LENGTH_MSB:SCR_LENGTH_LSB] = 10'(length);
        ack_count = 0;
        write_register(REG_MEM_ADDRESS, address);
        write_register(REG_MEM_SCR, scr);
    endtask

    task automatic wait_transfer_done();
        int polls;
        polls = 0;
        read_registers(REG_MEM_SCR, 1);
        while (reg_values[0][SCR_BUSY_BIT]) begin
            polls++;
            if (polls > 20) begin
                abort_run("Transfer still busy after 20 status polls");
            end
            read_registers(REG_MEM_SCR, 1);
        end
    endtask

    // ==============================
    // Scenarios
    // ==============================

    initial begin
        byte_t rx;
        reg_word_t address_value;
        reg_word_t stop_value;
        mem_addr_t base;

        lcg_state = 32'd71;
        reset = 1'b1;
        button = 1'b0;
        sd_det = 1'b0;
        mcu_clk = 1'b0;
        mcu_cs = 1'b1;
        mcu_mosi = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        ack_count = 0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        clk_cycles(4);

        if (mem_request !== 1'b0) begin
            abort_run("mem_request is not low after reset");
        end
        frame_begin(CMD_IDENTIFY);
        spi_byte(8'h00, rx);
        check_byte("identify response", rx, FPGA_ID);
        spi_byte(8'h00, rx);
        check_byte("identify response", rx, FPGA_ID);
        frame_end();
        frame_begin(8'h7f);
        spi_byte(8'h00, rx);
        check_byte("unknown command response", rx, 8'h00);
        spi_byte(8'h00, rx);
        check_byte("unknown command response", rx, 8'h00);
        frame_end();

        // Register write, read back and auto-increment
        address_value = lcg_next();
        write_register(REG_MEM_ADDRESS, address_value);
        read_registers(REG_MEM_ADDRESS, 1);
        check_reg("MEM_ADDRESS", reg_values[0], address_value);
        read_registers(REG_STATUS, 2);
        check_reg("STATUS", reg_values[0], status_ref(1'b0, 1'b0, 1'b0));
        check_reg("MEM_ADDRESS after STATUS", reg_values[1], address_value);

        for (int combo = 0; combo < 4; combo++) begin
            button = combo[0];
            sd_det = combo[1];
            clk_cycles(8);
            read_registers(REG_STATUS, 1);
            check_reg("STATUS", reg_values[0], status_ref(combo[0], combo[1], 1'b0));
        end
        button = 1'b0;
        sd_det = 1'b0;

        for (int k = 0; k < 16; k++) begin
            buf_words[k] = mem_word_t'(lcg_next() >> 16);
        end
        write_buffer(16);
        read_buffer(16);
        for (int k = 0; k < 16; k++) begin
            check_mem_word("buffer word", read_words[k], buf_words[k]);
        end

        // Buffer to bus
        base = lcg_next() & 32'hffff_fffe;
        start_transfer(1'b1, base, 12);
        wait_transfer_done();
        if (ack_count != 12) begin
            abort_run($sformatf("Expected 12 bus acknowledges but saw %0d", ack_count));
        end
        for (int k = 0; k < 12; k++) begin
            check_bit("mem_write", bus_log_write[k], 1'b1);
            check_address("mem_address", bus_log_addr[k], base + mem_addr_t'(2 * k));
            check_mem_word("mem_wdata", bus_log_data[k], buf_words[k]);
        end
        read_registers(REG_MEM_SCR, 1);
        check_reg("MEM_SCR", reg_values[0], 32'h0);

        // Bus to buffer
        base = lcg_next() & 32'hffff_fffe;
        start_transfer(1'b0, base, 12);
        wait_transfer_done();
        if (ack_count != 12) begin
            abort_run($sformatf("Expected 12 bus acknowledges but saw %0d", ack_count));
        end
        read_buffer(12);
        for (int k = 0; k < 12; k++) begin
            check_bit("mem_write", bus_log_write[k], 1'b0);
            check_mem_word("buffer word from bus", read_words[k],
                           mem_ref_word(base + mem_addr_t'(2 * k)));
        end

        // A full-length burst cut short by a stop
        base = lcg_next() & 32'hffff_fffe;
        start_transfer(1'b0, base, BUF_DEPTH);
        stop_value = '0;
        stop_value[SCR_STOP_BIT] = 1'b1;
        write_register(REG_MEM_SCR, stop_value);
        wait_transfer_done();
        if ((ack_count == 0) || (ack_count >= BUF_DEPTH)) begin
            abort_run($sformatf("Stopped burst saw %0d acknowledges out of %0d",
                                ack_count, BUF_DEPTH));
        end

        if (UUT.bus_checks.failure_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* list.f */
verilog/mcu_protocol_pkg.sv
verilog/mcu_regs_pkg.sv
verilog/mcu_spi_link.sv
verilog/mcu_command_decoder.sv
verilog/mcu_register_block.sv
verilog/mem_transfer_engine.sv
verilog/mcu_bridge_top.sv
testbench/mcu_bridge_assertions.sv
testbench/tb_mcu_bridge.sv

/* Bender.yml */
package:
  name: mcu_bridge

sources:
  - verilog/mcu_protocol_pkg.sv
  - verilog/mcu_regs_pkg.sv
  - verilog/mcu_spi_link.sv
  - verilog/mcu_command_decoder.sv
  - verilog/mcu_register_block.sv
  - verilog/mem_transfer_engine.sv
  - verilog/mcu_bridge_top.sv
  - target: test
    files:
      - testbench/mcu_bridge_assertions.sv
      - testbench/tb_mcu_bridge.sv
